/* hw/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // CPU and memory address width
    localparam int ADDR_W     = 32;
    localparam int BYTE_OFS_W = 2;   // Byte offset inside a word

    // Data or address word on either bus
    typedef logic [ADDR_W-1:0] word_t;

    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_fetch = 2'b01,   // Read miss, waiting on memory
        st_write = 2'b10    // Write-through in flight
    } cache_state_t;

endpackage

`default_nettype wire

/* hw/cache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 7
) (
    input  wire        clk,
    input  wire        reset,
    input  wire word_t lookup_addr,
    input  wire        fill,
    input  wire word_t fill_addr,
    output logic       hit
);

    localparam int TAG_BITS = ADDR_W - INDEX_BITS - BYTE_OFS_W;
    localparam int LINES    = 1 << INDEX_BITS;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    logic [LINES-1:0] valid;
    tag_t             tags [LINES];

    index_t lookup_idx;
    tag_t   lookup_tag;
    index_t fill_idx;
    tag_t   fill_tag;

    // Address fields
    assign lookup_idx = lookup_addr[BYTE_OFS_W +: INDEX_BITS];
    assign lookup_tag = lookup_addr[ADDR_W-1 -: TAG_BITS];
    assign fill_idx   = fill_addr[BYTE_OFS_W +: INDEX_BITS];
    assign fill_tag   = fill_addr[ADDR_W-1 -: TAG_BITS];

    assign hit = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);

    // Whole cache invalid after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (fill) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_idx] <= fill_tag;   // New owner of the line
        end
    end

endmodule

`default_nettype wire

/* hw/cache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_data_store
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 7
) (
    input  wire        clk,
    input  wire word_t lookup_addr,
    input  wire word_t wr_data,
    input  wire        hit_wr,
    input  wire        fill,
    input  wire word_t fill_addr,
    input  wire word_t fill_data,
    output word_t      rdata
);

    localparam int LINES = 1 << INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;

    word_t  words [LINES];
    index_t lookup_idx;
    index_t wr_idx;
    word_t  wr_word;

    assign lookup_idx = lookup_addr[BYTE_OFS_W +: INDEX_BITS];

    // Single write port, fill wins over hit write
    assign wr_idx  = fill ? fill_addr[BYTE_OFS_W +: INDEX_BITS] : lookup_idx;
    assign wr_word = fill ? fill_data : wr_data;

    always_ff @(posedge clk) begin
        if (fill || hit_wr) begin
            words[wr_idx] <= wr_word;
        end
    end

    // Forward memory word in the ready cycle of a miss
    assign rdata = fill ? fill_data : words[lookup_idx];

endmodule

`default_nettype wire

/* hw/cache_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_mem_port
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 7
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        capture,
    input  wire        rd_sel,
    input  wire        wr_sel,
    input  wire        done,
    input  wire word_t cpu_addr,
    input  wire word_t cpu_wdata,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic       mem_read,
    output logic       mem_write
);

    localparam int TAG_BITS = ADDR_W - INDEX_BITS - BYTE_OFS_W;

    logic [TAG_BITS-1:0]   tag_q;
    logic [INDEX_BITS-1:0] index_q;

    // Request capture, payload only
    always_ff @(posedge clk) begin
        if (capture) begin
            tag_q     <= cpu_addr[ADDR_W-1 -: TAG_BITS];
            index_q   <= cpu_addr[BYTE_OFS_W +: INDEX_BITS];
            mem_wdata <= cpu_wdata;
        end
    end

    // Word aligned bus address, also the fill address
    assign mem_addr = {tag_q, index_q, {BYTE_OFS_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else if (capture) begin
            mem_read  <= rd_sel;
            mem_write <= wr_sel;
        end else if (done) begin
            mem_read  <= 1'b0;   // Transfer ended last cycle
            mem_write <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input  wire  clk,
    input  wire  reset,
    input  wire  cpu_read,
    input  wire  cpu_write,
    input  wire  hit,
    input  wire  mem_ready,
    output logic cpu_stall,
    output logic capture,
    output logic rd_sel,
    output logic wr_sel,
    output logic fill,
    output logic hit_wr,
    output logic done
);

    cache_state_t state;
    cache_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        cpu_stall  = 1'b0;
        capture    = 1'b0;
        rd_sel     = 1'b0;
        wr_sel     = 1'b0;
        fill       = 1'b0;
        hit_wr     = 1'b0;
        done       = 1'b0;

        case (state)
            st_idle: begin
                if (cpu_write) begin
                    // Every write goes through to memory
                    cpu_stall  = 1'b1;
                    capture    = 1'b1;
                    wr_sel     = 1'b1;
                    hit_wr     = hit;   // No allocate on a miss
                    next_state = st_write;
                end else if (cpu_read && !hit) begin
                    cpu_stall  = 1'b1;
                    capture    = 1'b1;
                    rd_sel     = 1'b1;
                    next_state = st_fetch;
                end
                // Read hit completes here with no stall
            end

            st_fetch: begin
                cpu_stall = !mem_ready;
                if (mem_ready) begin
                    fill       = 1'b1;   // Line write and forward
                    done       = 1'b1;
                    next_state = st_idle;
                end
            end

            st_write: begin
                cpu_stall = !mem_ready;
                if (mem_ready) begin
                    done       = 1'b1;
                    next_state = st_idle;
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/riscv32i_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv32i_cache
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 7   // 128 lines by default
) (
    input  wire        clk,
    input  wire        reset,
    input  wire word_t cpu_addr,
    input  wire        cpu_read,
    input  wire        cpu_write,
    input  wire word_t cpu_wdata,
    output word_t      cpu_rdata,
    output logic       cpu_stall,
    output word_t      mem_addr,
    output logic       mem_read,
    output logic       mem_write,
    output word_t      mem_wdata,
    input  wire word_t mem_rdata,
    input  wire        mem_ready
);

    logic hit;
    logic capture;
    logic rd_sel;
    logic wr_sel;
    logic fill;
    logic hit_wr;
    logic done;

    cache_ctrl ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .cpu_read  (cpu_read),
        .cpu_write (cpu_write),
        .hit       (hit),
        .mem_ready (mem_ready),
        .cpu_stall (cpu_stall),
        .capture   (capture),
        .rd_sel    (rd_sel),
        .wr_sel    (wr_sel),
        .fill      (fill),
        .hit_wr    (hit_wr),
        .done      (done)
    );

    cache_tag_store #(.INDEX_BITS(INDEX_BITS)) tag_inst (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (cpu_addr),
        .fill        (fill),
        .fill_addr   (mem_addr),   // Captured miss address
        .hit         (hit)
    );

    cache_data_store #(.INDEX_BITS(INDEX_BITS)) data_inst (
        .clk         (clk),
        .lookup_addr (cpu_addr),
        .wr_data     (cpu_wdata),
        .hit_wr      (hit_wr),
        .fill        (fill),
        .fill_addr   (mem_addr),
        .fill_data   (mem_rdata),
        .rdata       (cpu_rdata)
    );

    cache_mem_port #(.INDEX_BITS(INDEX_BITS)) mem_inst (
        .clk       (clk),
        .reset     (reset),
        .capture   (capture),
        .rd_sel    (rd_sel),
        .wr_sel    (wr_sel),
        .done      (done),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

endmodule

`default_nettype wire

/* bench/cache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_mem_model
    import cache_pkg::*;
#(
    parameter int READY_DELAY = 3,   // Strobe cycles before mem_ready
    parameter int DEPTH_BITS  = 10
) (
    input  wire        clk,
    input  wire        reset,
    input  wire word_t mem_addr,
    input  wire        mem_read,
    input  wire        mem_write,
    input  wire word_t mem_wdata,
    output word_t      mem_rdata,
    output logic       mem_ready
);

    word_t                 words [1 << DEPTH_BITS];
    int                    wait_cnt;
    logic [DEPTH_BITS-1:0] word_idx;

    assign word_idx = mem_addr[BYTE_OFS_W +: DEPTH_BITS];

    // Preload, each word tied to its own byte address
    initial begin
        mem_rdata = '0;
        mem_ready = 1'b0;
        for (int i = 0; i < (1 << DEPTH_BITS); i++) begin
            words[i] = (i << 2) ^ (i << 18) ^ 32'h5A3C_0000;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            wait_cnt  <= 0;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;   // Strobe falls on this edge
            wait_cnt  <= 0;
        end else if (mem_read || mem_write) begin
            if (wait_cnt == READY_DELAY - 1) begin
                mem_ready <= 1'b1;
                if (mem_write) begin
                    words[word_idx] <= mem_wdata;
                end else begin
                    mem_rdata <= words[word_idx];
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb
    import cache_pkg::*;
();

    localparam int INDEX_BITS  = 7;
    localparam int READY_DELAY = 3;
    localparam int MEM_WORDS   = 1024;

    logic  clk;
    logic  reset;
    word_t cpu_addr;
    logic  cpu_read;
    logic  cpu_write;
    word_t cpu_wdata;
    word_t cpu_rdata;
    logic  cpu_stall;
    word_t mem_addr;
    logic  mem_read;
    logic  mem_write;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_ready;

    word_t shadow [MEM_WORDS];   // Expected memory image
    word_t lfsr_state;
    int    issued;

    riscv32i_cache #(.INDEX_BITS(INDEX_BITS)) riscv32i_cache_inst (.*);
    cache_mem_model #(.READY_DELAY(READY_DELAY)) mem_model_inst (.*);

    always #10 clk = ~clk;

    task automatic check_val(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic word_t rand_bits(input int n);
        word_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        reset     <= 1'b1;
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_val("cpu_stall", cpu_stall, 0);
        check_val("mem_read", mem_read, 0);
        check_val("mem_write", mem_write, 0);
    endtask

    task automatic cpu_rd(input word_t addr, output word_t data, output logic missed);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_read <= 1'b1;
        issued++;
        @(negedge clk);
        missed = cpu_stall;   // Stall in the request cycle means a miss
        while (cpu_stall) @(negedge clk);
        data = cpu_rdata;
        check_val("mem_read", mem_read, missed);   // Bus read only on a miss
        if (missed) begin
            check_val("mem_addr", mem_addr, {addr[31:2], 2'b00});
        end
        @(posedge clk);
        cpu_read <= 1'b0;
    endtask

    task automatic cpu_wr(input word_t addr, input word_t data);
        @(posedge clk);
        cpu_addr  <= addr;
        cpu_wdata <= data;
        cpu_write <= 1'b1;
        issued++;
        @(negedge clk);
        check_val("cpu_stall", cpu_stall, 1);
        while (cpu_stall) @(negedge clk);
        check_val("mem_write", mem_write, 1);
        check_val("mem_addr", mem_addr, {addr[31:2], 2'b00});
        check_val("mem_wdata", mem_wdata, data);
        @(posedge clk);
        cpu_write <= 1'b0;
        shadow[addr[11:2]] = data;   // Memory always updated by write-through
    endtask

    task automatic read_check(input word_t addr, input logic miss_exp);
        word_t data;
        logic  missed;
        cpu_rd(addr, data, missed);
        check_val("cpu_rdata", data, shadow[addr[11:2]]);
        check_val("read miss", missed, miss_exp);
    endtask

    task automatic cold_read();
        read_check(32'h40, 1'b1);
        read_check(32'h40, 1'b0);   // Now resident
    endtask

    task automatic write_hit_through();
        word_t value;
        value = rand_bits(32);
        read_check(32'h80, 1'b1);
        cpu_wr(32'h80, value);
        read_check(32'h80, 1'b0);
        check_val("memory word", mem_model_inst.words[32], value);
    endtask

    task automatic write_miss_no_alloc();
        word_t value;
        value = rand_bits(32);
        cpu_wr(32'h300, value);
        read_check(32'h300, 1'b1);   // No allocate on a write miss
    endtask

    task automatic evict_same_index();
        word_t a;
        word_t b;
        a = 32'h0C0;
        b = a + (1 << (INDEX_BITS + BYTE_OFS_W));   // Same index with another tag
        repeat (3) begin
            read_check(a, 1'b1);
            read_check(b, 1'b1);
        end
    endtask

    task automatic random_traffic();
        word_t addr;
        word_t data;
        logic  missed;
        for (int i = 0; i < 200; i++) begin
            addr = rand_bits(9) << 2;
            if (rand_bits(1)) begin
                cpu_wr(addr, rand_bits(32));
            end else begin
                cpu_rd(addr, data, missed);
                check_val("cpu_rdata", data, shadow[addr[11:2]]);
            end
        end
    endtask

    task automatic reset_invalidate();
        word_t data;
        logic  missed;
        cpu_rd(32'h40, data, missed);
        read_check(32'h40, 1'b0);
        apply_reset();
        read_check(32'h40, 1'b1);
    endtask

    // Limit grows with each issued request
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 200 * (issued + 1)) begin
                $display("Timeout: the cache stopped answering after %0d requests", issued);
                $display("STATUS: FAIL");
                $fatal(1, "Watchdog expired");
            end
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cpu_addr   = '0;
        cpu_read   = 1'b0;
        cpu_write  = 1'b0;
        cpu_wdata  = '0;
        lfsr_state = 32'h1668;
        issued     = 0;
        apply_reset();
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = mem_model_inst.words[i];
        end
        cold_read();
        write_hit_through();
        write_miss_no_alloc();
        evict_same_index();
        random_traffic();
        reset_invalidate();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_mem_port.sv
hw/cache_ctrl.sv
hw/riscv32i_cache.sv
bench/cache_mem_model.sv
bench/cache_tb.sv
